//--- common/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// on-chip ram depth in 32-bit words
`define SOC_RAM_WORDS 256

// address map
`define SOC_RAM_BASE   32'h0000_0000
`define SOC_FLASH_BASE 32'h0100_0000
`define SOC_REG_BASE   32'h0200_0000

// flash window is 16 MB, register block is 16 bytes
`define SOC_FLASH_BYTES 32'h0100_0000
`define SOC_REG_BYTES   32'h0000_0010

// standard single-bit read
`define SOC_FLASH_CMD_READ 8'h03

`endif

//--- common/soc_pkg.sv
package soc_pkg;

  ////////////////////////////////////////////////////////////
  // processor bus
  ////////////////////////////////////////////////////////////

  // a request with nonzero wstrb is a write
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_FLASH,
    TGT_REGS,
    TGT_NONE
  } bus_target_e;

  ////////////////////////////////////////////////////////////
  // flash port
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    FL_IDLE,
    FL_CMD,
    FL_ADDR,
    FL_DATA,
    FL_DONE
  } flash_state_e;

  typedef struct packed {
    logic       enable;
    logic [7:0] clk_div;
  } flash_cfg_t;

endpackage

//--- sources.f
+incdir+common
common/soc_pkg.sv
verilog/soc_bus_decode.sv
verilog/soc_ram.sv
spi_flash/spi_flash_regs.sv
spi_flash/spi_flash_ctrl.sv
verilog/littlesoc.sv
tests/flash_model.sv
tests/tb_littlesoc.sv

//--- spi_flash/spi_flash_ctrl.sv
`include "soc_macros.svh"

module spi_flash_ctrl
  import soc_pkg::*;
(
  input  var logic       clk,
  input  var logic       reset,
  input  var mem_req_t   req,
  output var mem_rsp_t   rsp,
  input  var flash_cfg_t flash_cfg,
  output var logic       flash_cs,
  output var logic       flash_clk,
  inout  tri             flash_io0,
  inout  tri             flash_io1,
  inout  tri             flash_io2,
  inout  tri             flash_io3
);
  flash_state_e state;
  logic         ready;
  logic [31:0]  rdata;
  logic [7:0]   div;
  logic [7:0]   div_cnt;
  logic [5:0]   bit_cnt;
  logic [31:0]  sout;
  logic [31:0]  sin;
  logic         accept;
  logic         quick;
  logic         active;
  logic         phase_end;
  logic         rise;
  logic         fall;

  assign accept = (state == FL_IDLE) && req.valid && !ready;
  // writes and a disabled port are acknowledged without touching the pins
  assign quick  = (req.wstrb != 4'h0) || !flash_cfg.enable;

  assign active    = (state == FL_CMD) || (state == FL_ADDR) || (state == FL_DATA);
  assign phase_end = active && (div_cnt == div);
  assign rise      = phase_end && !flash_clk;
  assign fall      = phase_end && flash_clk;

  ////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= FL_IDLE;
      ready     <= 1'b0;
      flash_cs  <= 1'b1;
      flash_clk <= 1'b0;
      div_cnt   <= 8'h0;
      bit_cnt   <= 6'h0;
    end else begin
      ready <= 1'b0;
      case (state)
        FL_IDLE: begin
          if (accept && quick) begin
            ready <= 1'b1;
          end else if (accept) begin
            flash_cs  <= 1'b0;
            flash_clk <= 1'b0;
            div_cnt   <= 8'h0;
            bit_cnt   <= 6'h0;
            state     <= FL_CMD;
          end
        end
        FL_CMD, FL_ADDR, FL_DATA: begin
          if (phase_end) begin
            div_cnt   <= 8'h0;
            flash_clk <= !flash_clk;
          end else begin
            div_cnt <= div_cnt + 8'h1;
          end
          // a bit ends with its high phase
          if (fall) begin
            bit_cnt <= bit_cnt + 6'h1;
            if (bit_cnt == 6'd7) begin
              state <= FL_ADDR;
            end else if (bit_cnt == 6'd31) begin
              state <= FL_DATA;
            end else if (bit_cnt == 6'd63) begin
              state    <= FL_DONE;
              flash_cs <= 1'b1;
            end
          end
        end
        FL_DONE: begin
          ready <= 1'b1;
          state <= FL_IDLE;
        end
        default: state <= FL_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      div   <= flash_cfg.clk_div;
      sout  <= {`SOC_FLASH_CMD_READ, req.addr[23:0]};
      rdata <= 32'h0;
    end
    if (fall) begin
      sout <= {sout[30:0], 1'b0};
    end
    // flash changes io1 on the falling edge, so it is stable here
    if (rise && (state == FL_DATA)) begin
      sin <= {sin[30:0], flash_io1};
    end
    // first byte received goes to the low lane
    if (state == FL_DONE) begin
      rdata <= {sin[7:0], sin[15:8], sin[23:16], sin[31:24]};
    end
  end

  assign flash_io0 = flash_cs ? 1'bz : sout[31];
  assign flash_io1 = 1'bz;
  // write protect and hold inactive
  assign flash_io2 = 1'b1;
  assign flash_io3 = 1'b1;

  always_comb begin
    rsp.ready = ready;
    rsp.rdata = rdata;
  end

endmodule

//--- spi_flash/spi_flash_regs.sv
module spi_flash_regs
  import soc_pkg::*;
(
  input  var logic       clk,
  input  var logic       reset,
  input  var mem_req_t   req,
  output var mem_rsp_t   rsp,
  output var flash_cfg_t flash_cfg
);
  logic        ready;
  logic [31:0] rdata;
  logic        access;
  logic [1:0]  offset;

  assign access = req.valid && !ready;
  assign offset = req.addr[3:2];

  // both registers live in byte lane 0
  always_ff @(posedge clk) begin
    if (reset) begin
      ready     <= 1'b0;
      flash_cfg <= '{enable: 1'b1, clk_div: 8'h00};
    end else begin
      ready <= access;
      if (access && req.wstrb[0]) begin
        case (offset)
          2'd0:    flash_cfg.enable <= req.wdata[0];
          2'd1:    flash_cfg.clk_div <= req.wdata[7:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (offset)
        2'd0:    rdata <= {31'h0, flash_cfg.enable};
        2'd1:    rdata <= {24'h0, flash_cfg.clk_div};
        default: rdata <= 32'h0;
      endcase
    end
  end

  always_comb begin
    rsp.ready = ready;
    rsp.rdata = rdata;
  end

endmodule

//--- tests/flash_model.sv
`include "soc_macros.svh"

// serial flash that answers the single-bit read command
module flash_model (
  input  var logic cs,
  input  var logic sck,
  inout  tri       io0,
  inout  tri       io1,
  inout  tri       io2,
  inout  tri       io3
);
  logic [6:0]  edges = 7'd0;
  logic [31:0] header = 32'h0;
  logic        drive = 1'b0;
  logic        dout = 1'b0;
  logic [23:0] byte_addr;
  logic [7:0]  byte_val;
  int          d;

  assign io1 = drive ? dout : 1'bz;

  always @(negedge cs) begin
    edges = 7'd0;
  end

  always @(posedge cs) begin
    drive <= 1'b0;
  end

  // command and address come in on io0, msb first
  always @(posedge sck) begin
    if (!cs && edges < 7'd64) begin
      if (edges < 7'd32) begin
        header = {header[30:0], io0};
      end
      edges = edges + 7'd1;
    end
  end

  // data goes out on io1 after each falling edge, msb of each byte first
  always @(negedge sck) begin
    if (!cs && edges >= 7'd32 && edges < 7'd64 && header[31:24] == `SOC_FLASH_CMD_READ) begin
      d = int'(edges) - 32;
      byte_addr = header[23:0] + 24'(d / 8);
      byte_val = byte_addr[7:0] ^ byte_addr[15:8] ^ 8'h5a;
      dout <= byte_val[7 - (d % 8)];
      drive <= 1'b1;
    end
  end

endmodule

//--- tests/tb_littlesoc.sv
`include "soc_macros.svh"

module tb_littlesoc
  import soc_pkg::*;
();
  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int N_RAM_OPS   = 200;
  localparam int N_FLASH_OPS = 50;
  // every transfer of the sequence plus some margin
  localparam longint N_XFERS = N_RAM_OPS + N_FLASH_OPS + 40;
  localparam longint WATCHDOG_CYCLES = N_XFERS * (64 * 2 * 256 + 10) + 16;
  localparam logic [31:0] UNMAPPED [4] = '{32'h0000_0400, 32'h0200_0010,
                                           32'h0300_0000, 32'hffff_fffc};

  logic     clk;
  logic     reset;
  mem_req_t bus_req;
  mem_rsp_t bus_rsp;
  wire      flash_cs;
  wire      flash_clk;
  tri       flash_io0;
  tri       flash_io1;
  tri       flash_io2;
  tri       flash_io3;

  logic [31:0] shadow [`SOC_RAM_WORDS];
  logic        flash_open;
  logic        phase_check;
  logic [7:0]  exp_div;
  int          hi_cycles;
  int          hi_phases;

  littlesoc i_dut (
    .clk       (clk),
    .reset     (reset),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .flash_cs  (flash_cs),
    .flash_clk (flash_clk),
    .flash_io0 (flash_io0),
    .flash_io1 (flash_io1),
    .flash_io2 (flash_io2),
    .flash_io3 (flash_io3)
  );

  flash_model i_flash (
    .cs  (flash_cs),
    .sck (flash_clk),
    .io0 (flash_io0),
    .io1 (flash_io1),
    .io2 (flash_io2),
    .io3 (flash_io3)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [7:0] flash_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  // little-endian word at the aligned address
  function automatic logic [31:0] flash_word(input logic [23:0] addr);
    logic [23:0] base;
    base = {addr[23:2], 2'b00};
    return {flash_byte(base + 24'd3), flash_byte(base + 24'd2),
            flash_byte(base + 24'd1), flash_byte(base)};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] wstrb);
    logic [31:0] merged;
    merged = old;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_rsp(input mem_rsp_t rsp, input logic [31:0] exp_rdata, input string what);
    if (rsp.ready !== 1'b1 || rsp.rdata !== exp_rdata) begin
      report_error($sformatf("%s: rdata %h ready %b, expected rdata %h",
                             what, rsp.rdata, rsp.ready, exp_rdata));
    end
  endtask

  task automatic check_pins(input logic exp_cs, input logic exp_clk, input string what);
    if (flash_cs !== exp_cs || flash_clk !== exp_clk) begin
      report_error($sformatf("%s: flash_cs %b flash_clk %b, expected %b %b",
                             what, flash_cs, flash_clk, exp_cs, exp_clk));
    end
  endtask

  task automatic check_count(input int got, input int expected, input string what);
    if (got != expected) begin
      report_error($sformatf("%s: got %0d, expected %0d", what, got, expected));
    end
  endtask

  // idle flash pins, write protect and hold, and flash_clk high phase length
  always @(negedge clk) begin
    if (flash_io2 !== 1'b1 || flash_io3 !== 1'b1) begin
      report_error($sformatf("write protect %b hold %b, expected both high",
                             flash_io2, flash_io3));
    end
    if (!reset && !flash_open) begin
      check_pins(1'b1, 1'b0, "flash pins with no read open");
    end
    if (phase_check) begin
      if (flash_clk === 1'b1) begin
        hi_cycles++;
      end else if (hi_cycles != 0) begin
        check_count(hi_cycles, int'(exp_div) + 1, "flash_clk high phase cycles");
        hi_phases++;
        hi_cycles = 0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // bus master
  ////////////////////////////////////////////////////////////

  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, output mem_rsp_t rsp, output int cycles);
    mem_req_t req;
    req.valid = 1'b1;
    req.instr = 1'b0;
    req.addr  = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    @(posedge clk);
    #DRIVE_DELAY;
    bus_req = req;
    cycles = 0;
    do begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end while (bus_rsp.ready !== 1'b1);
    rsp = bus_rsp;
    bus_req.valid = 1'b0;
  endtask

  task automatic flash_read(input logic [23:0] offs, output mem_rsp_t rsp);
    int cycles;
    flash_open = 1'b1;
    bus_xfer(`SOC_FLASH_BASE | {8'h0, offs}, 32'h0, 4'h0, rsp, cycles);
    flash_open = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("The run hung: the bus transfers did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    mem_rsp_t    rsp;
    int          cycles;
    int          idx;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] expected;
    logic [23:0] foffs;
    logic [7:0]  div;

    void'($urandom(32'h6b26));
    reset = 1'b1;
    bus_req = '0;
    flash_open = 1'b0;
    phase_check = 1'b0;
    exp_div = 8'h0;
    hi_cycles = 0;
    hi_phases = 0;
    for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
      shadow[i] = 32'h0;
    end
    repeat (16) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    @(negedge clk);
    check_pins(1'b1, 1'b0, "flash pins after reset");
    if (bus_rsp.ready !== 1'b0) begin
      report_error("bus_rsp.ready is high after reset");
    end
    bus_xfer(`SOC_REG_BASE, 32'h0, 4'h0, rsp, cycles);
    check_rsp(rsp, 32'h1, "enable after reset");
    bus_xfer(`SOC_REG_BASE + 32'h4, 32'h0, 4'h0, rsp, cycles);
    check_rsp(rsp, 32'h0, "clk_div after reset");

    // ram returns the old word and merges strobed bytes
    for (int n = 0; n < N_RAM_OPS; n++) begin
      addr = `SOC_RAM_BASE + $urandom_range(4 * `SOC_RAM_WORDS - 1, 0);
      wdata = $urandom();
      wstrb = ($urandom_range(1, 0) == 1) ? 4'($urandom_range(15, 1)) : 4'h0;
      idx = int'(addr >> 2) % `SOC_RAM_WORDS;
      expected = shadow[idx];
      bus_xfer(addr, wdata, wstrb, rsp, cycles);
      check_rsp(rsp, expected, $sformatf("ram access at %h strobe %h", addr, wstrb));
      check_count(cycles, 1, "ram latency");
      shadow[idx] = merge_bytes(expected, wdata, wstrb);
    end

    for (int n = 0; n < N_FLASH_OPS; n++) begin
      foffs = 24'($urandom()) & 24'hff_fffc;
      flash_read(foffs, rsp);
      check_rsp(rsp, flash_word(foffs), $sformatf("flash read at %h", foffs));
    end

    div = 8'($urandom_range(7, 1));
    bus_xfer(`SOC_REG_BASE + 32'h4, {24'h0, div}, 4'h1, rsp, cycles);
    bus_xfer(`SOC_REG_BASE + 32'h4, 32'h0, 4'h0, rsp, cycles);
    check_rsp(rsp, {24'h0, div}, "clk_div read back");
    exp_div = div;
    phase_check = 1'b1;
    foffs = 24'($urandom()) & 24'hff_fffc;
    flash_read(foffs, rsp);
    phase_check = 1'b0;
    check_rsp(rsp, flash_word(foffs), $sformatf("flash read at %h, clk_div %0d", foffs, div));
    check_count(hi_phases, 64, "flash_clk high phases in one read");
    for (int n = 0; n < 2; n++) begin
      foffs = 24'($urandom()) & 24'hff_fffc;
      flash_read(foffs, rsp);
      check_rsp(rsp, flash_word(foffs), $sformatf("flash read at %h, clk_div %0d", foffs, div));
    end
    bus_xfer(`SOC_REG_BASE + 32'h4, 32'h0, 4'h1, rsp, cycles);

    // unmapped space and the empty register offsets
    for (int n = 0; n < 4; n++) begin
      bus_xfer(UNMAPPED[n], 32'hffff_ffff, 4'hf, rsp, cycles);
      check_rsp(rsp, 32'h0, $sformatf("unmapped write at %h", UNMAPPED[n]));
      check_count(cycles, 1, "unmapped latency");
      bus_xfer(UNMAPPED[n], 32'h0, 4'h0, rsp, cycles);
      check_rsp(rsp, 32'h0, $sformatf("unmapped read at %h", UNMAPPED[n]));
    end
    // bit 0 clear so a stray write would show up in enable
    for (int n = 2; n < 4; n++) begin
      bus_xfer(`SOC_REG_BASE + 32'(4 * n), 32'hffff_fffe, 4'hf, rsp, cycles);
      bus_xfer(`SOC_REG_BASE + 32'(4 * n), 32'h0, 4'h0, rsp, cycles);
      check_rsp(rsp, 32'h0, $sformatf("register offset %0d", 4 * n));
    end
    bus_xfer(`SOC_REG_BASE, 32'h0, 4'h0, rsp, cycles);
    check_rsp(rsp, 32'h1, "enable after empty register writes");
    bus_xfer(`SOC_REG_BASE + 32'h4, 32'h0, 4'h0, rsp, cycles);
    check_rsp(rsp, 32'h0, "clk_div after empty register writes");
    bus_xfer(`SOC_RAM_BASE, 32'h0, 4'h0, rsp, cycles);
    check_rsp(rsp, shadow[0], "ram word 0 after unmapped writes");
    foffs = 24'($urandom()) & 24'hff_fffc;
    bus_xfer(`SOC_FLASH_BASE | {8'h0, foffs}, $urandom(), 4'hf, rsp, cycles);
    check_rsp(rsp, 32'h0, "flash window write");
    check_count(cycles, 1, "flash write latency");
    flash_read(foffs, rsp);
    check_rsp(rsp, flash_word(foffs), "flash read after flash window write");

    // disabled port answers at once and leaves the pins idle
    bus_xfer(`SOC_REG_BASE, 32'h0, 4'h1, rsp, cycles);
    bus_xfer(`SOC_REG_BASE, 32'h0, 4'h0, rsp, cycles);
    check_rsp(rsp, 32'h0, "enable cleared");
    for (int n = 0; n < 3; n++) begin
      foffs = 24'($urandom()) & 24'hff_fffc;
      bus_xfer(`SOC_FLASH_BASE | {8'h0, foffs}, 32'h0, 4'h0, rsp, cycles);
      check_rsp(rsp, 32'h0, $sformatf("disabled flash read at %h", foffs));
      check_count(cycles, 1, "disabled flash read latency");
    end
    bus_xfer(`SOC_REG_BASE, 32'h1, 4'h1, rsp, cycles);
    foffs = 24'($urandom()) & 24'hff_fffc;
    flash_read(foffs, rsp);
    check_rsp(rsp, flash_word(foffs), "flash read after enable set again");

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog/littlesoc.sv
module littlesoc
  import soc_pkg::*;
(
  input  var logic     clk,
  input  var logic     reset,
  input  var mem_req_t bus_req,
  output var mem_rsp_t bus_rsp,
  output var logic     flash_cs,
  output var logic     flash_clk,
  inout  tri           flash_io0,
  inout  tri           flash_io1,
  inout  tri           flash_io2,
  inout  tri           flash_io3
);
  mem_req_t   ram_req;
  mem_req_t   flash_req;
  mem_req_t   reg_req;
  mem_rsp_t   ram_rsp;
  mem_rsp_t   flash_rsp;
  mem_rsp_t   reg_rsp;
  flash_cfg_t flash_cfg;

  soc_bus_decode i_decode (
    .clk       (clk),
    .reset     (reset),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .ram_req   (ram_req),
    .flash_req (flash_req),
    .reg_req   (reg_req),
    .ram_rsp   (ram_rsp),
    .flash_rsp (flash_rsp),
    .reg_rsp   (reg_rsp)
  );

  soc_ram i_ram (
    .clk   (clk),
    .reset (reset),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  // flash port configuration
  spi_flash_regs i_flash_regs (
    .clk       (clk),
    .reset     (reset),
    .req       (reg_req),
    .rsp       (reg_rsp),
    .flash_cfg (flash_cfg)
  );

  spi_flash_ctrl i_flash_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req       (flash_req),
    .rsp       (flash_rsp),
    .flash_cfg (flash_cfg),
    .flash_cs  (flash_cs),
    .flash_clk (flash_clk),
    .flash_io0 (flash_io0),
    .flash_io1 (flash_io1),
    .flash_io2 (flash_io2),
    .flash_io3 (flash_io3)
  );

endmodule

//--- verilog/soc_bus_decode.sv
`include "soc_macros.svh"

module soc_bus_decode
  import soc_pkg::*;
(
  input  var logic     clk,
  input  var logic     reset,
  input  var mem_req_t bus_req,
  output var mem_rsp_t bus_rsp,
  output var mem_req_t ram_req,
  output var mem_req_t flash_req,
  output var mem_req_t reg_req,
  input  var mem_rsp_t ram_rsp,
  input  var mem_rsp_t flash_rsp,
  input  var mem_rsp_t reg_rsp
);
  localparam logic [31:0] RAM_BYTES = 32'(4 * `SOC_RAM_WORDS);

  bus_target_e tgt;
  logic        none_ready;

  // unsigned offset compare covers both ends of each window
  always_comb begin
    if ((bus_req.addr - `SOC_RAM_BASE) < RAM_BYTES) begin
      tgt = TGT_RAM;
    end else if ((bus_req.addr - `SOC_FLASH_BASE) < `SOC_FLASH_BYTES) begin
      tgt = TGT_FLASH;
    end else if ((bus_req.addr - `SOC_REG_BASE) < `SOC_REG_BYTES) begin
      tgt = TGT_REGS;
    end else begin
      tgt = TGT_NONE;
    end
  end

  always_comb begin
    ram_req         = bus_req;
    ram_req.valid   = bus_req.valid && (tgt == TGT_RAM);
    flash_req       = bus_req;
    flash_req.valid = bus_req.valid && (tgt == TGT_FLASH);
    reg_req         = bus_req;
    reg_req.valid   = bus_req.valid && (tgt == TGT_REGS);
  end

  // unmapped accesses get an empty answer one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      none_ready <= 1'b0;
    end else begin
      none_ready <= bus_req.valid && (tgt == TGT_NONE) && !none_ready;
    end
  end

  always_comb begin
    case (tgt)
      TGT_RAM:   bus_rsp = ram_rsp;
      TGT_FLASH: bus_rsp = flash_rsp;
      TGT_REGS:  bus_rsp = reg_rsp;
      default:   bus_rsp = '{ready: none_ready, rdata: 32'h0};
    endcase
  end

endmodule

//--- verilog/soc_ram.sv
`include "soc_macros.svh"

module soc_ram
  import soc_pkg::*;
(
  input  var logic     clk,
  input  var logic     reset,
  input  var mem_req_t req,
  output var mem_rsp_t rsp
);
  localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

  logic [31:0]      mem [`SOC_RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             ready;
  logic [31:0]      rdata;
  logic             access;

  assign idx = req.addr[IDX_W+1:2];
  // no second access while valid is still held after ready
  assign access = req.valid && !ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
      for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
        mem[i] <= 32'h0;
      end
    end else begin
      ready <= access;
      if (access) begin
        for (int b = 0; b < 4; b++) begin
          if (req.wstrb[b]) begin
            mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // read returns the word as it was before any write
  always_ff @(posedge clk) begin
    if (access) begin
      rdata <= mem[idx];
    end
  end

  always_comb begin
    rsp.ready = ready;
    rsp.rdata = rdata;
  end

endmodule
